/* vlog.f */
sched_cfg_pkg.sv
ctrl_msg_pkg.sv
slot_if.sv
ctrl_msg_decoder.sv
slot_keeper.sv
desc_allocator.sv
scheduler_top.sv
scheduler_assert.sv
tb_clk_gen.sv
tb_scheduler.sv

/* run.sh */
#!/bin/sh
# Build and run the scheduler testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert -f vlog.f --top-module tb_scheduler -o sim_scheduler
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_scheduler +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
  exit 0
fi
echo "Pass message not found in sim.log"
exit 1

/* tb_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_scheduler;

  localparam int cw    = ctrl_msg_pkg::CTRL_WIDTH;
  localparam int tw    = ctrl_msg_pkg::MSG_TYPE_WIDTH;
  localparam int dw    = ctrl_msg_pkg::DESC_WIDTH;
  localparam int sw    = sched_cfg_pkg::SLOT_WIDTH;
  localparam int iw    = sched_cfg_pkg::CORE_ID_WIDTH;
  localparam int cores = sched_cfg_pkg::CORE_COUNT;
  // Six tests of up to about 300 cycles each, plus margin
  localparam int max_cycles = 3000;

  logic                                   clk;
  logic                                   rst_r;
  logic [cw-1:0]                          ctrl_in_data;
  logic [iw-1:0]                          ctrl_in_src;
  logic                                   ctrl_in_valid;
  logic                                   ctrl_in_ready;
  logic [cw-1:0]                          ctrl_out_data;
  logic [iw-1:0]                          ctrl_out_dest;
  logic                                   ctrl_out_valid;
  logic                                   ctrl_out_ready;
  logic [iw-1:0]                          rx_req_core;
  logic                                   rx_req_valid;
  logic                                   rx_req_ready;
  logic [sched_cfg_pkg::ID_TAG_WIDTH-1:0] rx_desc;
  logic                                   rx_desc_valid;
  logic                                   rx_desc_ready;
  logic [iw-1:0]                          stat_core;
  logic [sw-1:0]                          stat_slot_count;

  // Reference model: free slots per core and outputs still to come
  logic [sw-1:0]                          free_model [cores][$];
  logic [sched_cfg_pkg::ID_TAG_WIDTH-1:0] exp_desc [$];
  logic [iw+cw-1:0]                       exp_out [$];

  int   errors = 0;
  int   cycles = 0;
  int   test_base = 0;
  int   tests_failed = 0;
  logic rand_ready_on = 1'b0;

  tb_clk_gen #(.period_ns(40), .reset_cycles(8)) u_clk_gen (.clk(clk), .rst_r(rst_r));

  scheduler_top u_dut (
    .clk             (clk),
    .rst_r           (rst_r),
    .ctrl_in_data    (ctrl_in_data),
    .ctrl_in_src     (ctrl_in_src),
    .ctrl_in_valid   (ctrl_in_valid),
    .ctrl_in_ready   (ctrl_in_ready),
    .ctrl_out_data   (ctrl_out_data),
    .ctrl_out_dest   (ctrl_out_dest),
    .ctrl_out_valid  (ctrl_out_valid),
    .ctrl_out_ready  (ctrl_out_ready),
    .rx_req_core     (rx_req_core),
    .rx_req_valid    (rx_req_valid),
    .rx_req_ready    (rx_req_ready),
    .rx_desc         (rx_desc),
    .rx_desc_valid   (rx_desc_valid),
    .rx_desc_ready   (rx_desc_ready),
    .stat_core       (stat_core),
    .stat_slot_count (stat_slot_count)
  );

  function automatic int total_errors();
    return errors + u_dut.u_assert.failures;
  endfunction

  function automatic logic [cw-1:0] slot_word(input logic [tw-1:0] msg_type,
                                              input logic [sw-1:0] slot);
    logic [cw-1:0] w;
    w = '0;
    w[cw-1 -: tw] = msg_type;
    w[ctrl_msg_pkg::SLOT_FIELD_OFFSET +: sw] = slot;
    return w;
  endfunction

  function automatic logic [cw-1:0] done_word(input logic [dw-1:0] payload);
    return {ctrl_msg_pkg::MSG_PKT_DONE, payload};
  endfunction

  task automatic report_mismatch(input string msg);
    $display("MISMATCH at %0t: %s", $time, msg);
    errors++;
  endtask

  // Offers one control word and updates the model when it is taken
  task automatic send_ctrl(input logic [cw-1:0] word, input logic [iw-1:0] src);
    logic [tw-1:0] msg_type;
    msg_type = word[cw-1 -: tw];
    ctrl_in_data  = word;
    ctrl_in_src   = src;
    ctrl_in_valid = 1'b1;
    @(negedge clk);
    while (!ctrl_in_ready)
      @(negedge clk);
    @(posedge clk);
    if (msg_type == ctrl_msg_pkg::MSG_SLOT_INIT) begin
      free_model[src].delete();
      for (int s = 1; s <= int'(word[ctrl_msg_pkg::SLOT_FIELD_OFFSET +: sw]) &&
           s <= sched_cfg_pkg::SLOT_COUNT; s++)
        free_model[src].push_back(sw'(s));
    end else if (msg_type == ctrl_msg_pkg::MSG_SLOT_FREE) begin
      if (free_model[src].size() < sched_cfg_pkg::SLOT_COUNT)
        free_model[src].push_back(word[ctrl_msg_pkg::SLOT_FIELD_OFFSET +: sw]);
    end else if (msg_type == ctrl_msg_pkg::MSG_PKT_DONE) begin
      exp_out.push_back({src, ctrl_msg_pkg::MSG_SEND_OUT, word[dw-1:0]});
    end
    #2;
    ctrl_in_valid = 1'b0;
  endtask

  task automatic request_desc(input logic [iw-1:0] core);
    rx_req_core  = core;
    rx_req_valid = 1'b1;
    @(negedge clk);
    while (!rx_req_ready)
      @(negedge clk);
    @(posedge clk);
    if (free_model[core].size() == 0) begin
      $display("Request for core %0d was accepted with no free slot left", core);
      errors++;
    end else begin
      exp_desc.push_back({core, {(sched_cfg_pkg::TAG_WIDTH - sw){1'b0}},
                          free_model[core].pop_front()});
    end
    #2;
    rx_req_valid = 1'b0;
  endtask

  task automatic expect_refused(input logic [iw-1:0] core, input int n);
    rx_req_core  = core;
    rx_req_valid = 1'b1;
    repeat (n) begin
      @(negedge clk);
      if (rx_req_ready)
        report_mismatch($sformatf("rx_req_ready high for core %0d, expected low", core));
    end
    @(posedge clk);
    #2;
    rx_req_valid = 1'b0;
  endtask

  task automatic check_count(input logic [iw-1:0] core);
    stat_core = core;
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (stat_slot_count !== sw'(free_model[core].size()))
      report_mismatch($sformatf("core %0d count %0d, expected %0d", core,
                                stat_slot_count, free_model[core].size()));
    @(posedge clk);
    #2;
  endtask

  task automatic wait_drain(input int limit);
    int n;
    n = 0;
    while ((exp_desc.size() != 0 || exp_out.size() != 0) && n < limit) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (n >= limit) begin
      $display("Outputs still pending after %0d cycles: %0d descriptors, %0d send-out words",
               limit, exp_desc.size(), exp_out.size());
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name);
    int found;
    found = total_errors() - test_base;
    if (found == 0) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", num, name, found);
      tests_failed++;
    end
    test_base = total_errors();
  endtask

  // Outputs are read mid-cycle, where they are settled
  always @(negedge clk) begin
    if (!rst_r && rx_desc_valid && rx_desc_ready) begin
      if (exp_desc.size() == 0) begin
        $display("Descriptor %h arrived at %0t with none outstanding", rx_desc, $time);
        errors++;
      end else begin
        if (rx_desc !== exp_desc[0])
          report_mismatch($sformatf("rx_desc %h, expected %h", rx_desc, exp_desc[0]));
        void'(exp_desc.pop_front());
      end
    end
    if (!rst_r && ctrl_out_valid && ctrl_out_ready) begin
      if (exp_out.size() == 0) begin
        $display("Send-out word %h arrived at %0t with none outstanding", ctrl_out_data, $time);
        errors++;
      end else begin
        if ({ctrl_out_dest, ctrl_out_data} !== exp_out[0])
          report_mismatch($sformatf("ctrl_out dest %0d data %h, expected %h",
                                    ctrl_out_dest, ctrl_out_data, exp_out[0]));
        void'(exp_out.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    #2;
    if (rand_ready_on)
      ctrl_out_ready = 1'($urandom_range(0, 1));
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d cycles", max_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h4a1c_7357));
    ctrl_in_data   = '0;
    ctrl_in_src    = '0;
    ctrl_in_valid  = 1'b0;
    ctrl_out_ready = 1'b1;
    rx_req_core    = '0;
    rx_req_valid   = 1'b0;
    rx_desc_ready  = 1'b1;
    stat_core      = '0;
    wait (rst_r === 1'b0);
    @(posedge clk);
    #2;

    @(negedge clk);
    if (ctrl_out_valid !== 1'b0)
      report_mismatch("ctrl_out_valid high after reset");
    if (rx_desc_valid !== 1'b0)
      report_mismatch("rx_desc_valid high after reset");
    @(posedge clk);
    #2;
    for (int c = 0; c < cores; c++)
      check_count(iw'(c));
    end_test(1, "reset state");

    send_ctrl(slot_word(ctrl_msg_pkg::MSG_SLOT_INIT, 4'd5), 2'd1);
    check_count(2'd1);
    for (int c = 0; c < cores; c++)
      check_count(iw'(c));
    end_test(2, "slot init");

    for (int i = 0; i < 5; i++)
      request_desc(2'd1);
    wait_drain(50);
    expect_refused(2'd1, 4);
    check_count(2'd1);
    end_test(3, "drain one core");

    // Request waits on an empty core until a slot comes back
    fork
      request_desc(2'd0);
      begin
        repeat (3) @(posedge clk);
        #2;
        send_ctrl(slot_word(ctrl_msg_pkg::MSG_SLOT_FREE, 4'd6), 2'd0);
      end
    join
    wait_drain(50);
    check_count(2'd0);
    end_test(4, "slot free");

    ctrl_out_ready = 1'b0;
    for (int i = 0; i < 4; i++)
      send_ctrl(done_word($urandom), iw'(i));
    ctrl_in_data  = done_word(32'h5eed_0005);
    ctrl_in_src   = 2'd1;
    ctrl_in_valid = 1'b1;
    @(negedge clk);
    if (ctrl_in_ready !== 1'b0)
      report_mismatch("ctrl_in_ready high with four packet-done words waiting");
    rand_ready_on = 1'b1;
    @(posedge clk);
    #2;
    send_ctrl(done_word(32'h5eed_0005), 2'd1);
    for (int i = 0; i < 8; i++)
      send_ctrl(done_word($urandom), iw'($urandom_range(0, cores - 1)));
    wait_drain(200);
    rand_ready_on = 1'b0;
    @(posedge clk);
    #2;
    ctrl_out_ready = 1'b1;
    end_test(5, "packet done");

    rx_desc_ready = 1'b0;
    send_ctrl(slot_word(ctrl_msg_pkg::MSG_SLOT_INIT, 4'd3), 2'd2);
    request_desc(2'd2);
    expect_refused(2'd2, 4);
    rx_desc_ready = 1'b1;
    request_desc(2'd2);
    request_desc(2'd2);
    wait_drain(50);
    check_count(2'd2);
    end_test(6, "descriptor back-pressure");

    $display("tests run 6, failed %0d, errors %0d", tests_failed, total_errors());
    if (total_errors() == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int period_ns    = 40,
  parameter int reset_cycles = 8
) (
  output logic clk,
  output logic rst_r
);

  initial begin
    clk = 1'b0;
    forever #(period_ns / 2) clk = ~clk;
  end

  // Reset drops just after an edge, like the other inputs
  initial begin
    rst_r = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_r = 1'b0;
  end

endmodule

`default_nettype wire

/* scheduler_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module scheduler_assert (
  input logic                                    clk,
  input logic                                    rst_r,
  input logic [ctrl_msg_pkg::CTRL_WIDTH-1:0]     ctrl_out_data,
  input logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] ctrl_out_dest,
  input logic                                    ctrl_out_valid,
  input logic                                    ctrl_out_ready,
  input logic [sched_cfg_pkg::ID_TAG_WIDTH-1:0]  rx_desc,
  input logic                                    rx_desc_valid,
  input logic                                    rx_desc_ready
);

  int failures = 0;

  reset_idle: assert property (@(posedge clk)
    rst_r |=> !ctrl_out_valid && !rx_desc_valid)
    else begin
      $error("ctrl_out_valid or rx_desc_valid high after a reset cycle");
      failures++;
    end

  ctrl_out_hold: assert property (@(posedge clk) disable iff (rst_r)
    ctrl_out_valid && !ctrl_out_ready |=>
      ctrl_out_valid && $stable(ctrl_out_data) && $stable(ctrl_out_dest))
    else begin
      $error("ctrl_out dropped or changed while waiting for ready");
      failures++;
    end

  rx_desc_hold: assert property (@(posedge clk) disable iff (rst_r)
    rx_desc_valid && !rx_desc_ready |=> rx_desc_valid && $stable(rx_desc))
    else begin
      $error("rx_desc dropped or changed while waiting for ready");
      failures++;
    end

endmodule

bind scheduler_top scheduler_assert u_assert (
  .clk            (clk),
  .rst_r          (rst_r),
  .ctrl_out_data  (ctrl_out_data),
  .ctrl_out_dest  (ctrl_out_dest),
  .ctrl_out_valid (ctrl_out_valid),
  .ctrl_out_ready (ctrl_out_ready),
  .rx_desc        (rx_desc),
  .rx_desc_valid  (rx_desc_valid),
  .rx_desc_ready  (rx_desc_ready)
);

`default_nettype wire

/* scheduler_top.sv */
`timescale 1ns/1ps
`default_nettype none

module scheduler_top (
  input  logic                                    clk,
  input  logic                                    rst_r,

  input  logic [ctrl_msg_pkg::CTRL_WIDTH-1:0]     ctrl_in_data,
  input  logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] ctrl_in_src,
  input  logic                                    ctrl_in_valid,
  output logic                                    ctrl_in_ready,

  output logic [ctrl_msg_pkg::CTRL_WIDTH-1:0]     ctrl_out_data,
  output logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] ctrl_out_dest,
  output logic                                    ctrl_out_valid,
  input  logic                                    ctrl_out_ready,

  input  logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] rx_req_core,
  input  logic                                    rx_req_valid,
  output logic                                    rx_req_ready,

  output logic [sched_cfg_pkg::ID_TAG_WIDTH-1:0]  rx_desc,
  output logic                                    rx_desc_valid,
  input  logic                                    rx_desc_ready,

  input  logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] stat_core,
  output logic [sched_cfg_pkg::SLOT_WIDTH-1:0]    stat_slot_count
);

  slot_if slots ();

  ctrl_msg_decoder u_decoder (
    .clk            (clk),
    .rst_r          (rst_r),
    .ctrl_in_data   (ctrl_in_data),
    .ctrl_in_src    (ctrl_in_src),
    .ctrl_in_valid  (ctrl_in_valid),
    .ctrl_in_ready  (ctrl_in_ready),
    .ctrl_out_data  (ctrl_out_data),
    .ctrl_out_dest  (ctrl_out_dest),
    .ctrl_out_valid (ctrl_out_valid),
    .ctrl_out_ready (ctrl_out_ready),
    .slots          (slots)
  );

  // One free-slot FIFO per core
  for (genvar c = 0; c < sched_cfg_pkg::CORE_COUNT; c++) begin : g_keeper
    slot_keeper #(
      .core_index (c)
    ) u_keeper (
      .clk   (clk),
      .rst_r (rst_r),
      .slots (slots)
    );
  end

  desc_allocator u_allocator (
    .clk             (clk),
    .rst_r           (rst_r),
    .rx_req_core     (rx_req_core),
    .rx_req_valid    (rx_req_valid),
    .rx_req_ready    (rx_req_ready),
    .rx_desc         (rx_desc),
    .rx_desc_valid   (rx_desc_valid),
    .rx_desc_ready   (rx_desc_ready),
    .stat_core       (stat_core),
    .stat_slot_count (stat_slot_count),
    .slots           (slots)
  );

endmodule

`default_nettype wire

/* desc_allocator.sv */
`timescale 1ns/1ps
`default_nettype none

module desc_allocator (
  input  logic                                    clk,
  input  logic                                    rst_r,
  input  logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] rx_req_core,
  input  logic                                    rx_req_valid,
  output logic                                    rx_req_ready,
  output logic [sched_cfg_pkg::ID_TAG_WIDTH-1:0]  rx_desc,
  output logic                                    rx_desc_valid,
  input  logic                                    rx_desc_ready,
  input  logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] stat_core,
  output logic [sched_cfg_pkg::SLOT_WIDTH-1:0]    stat_slot_count,
  slot_if.allocator                               slots
);

  logic                                 out_free;
  logic                                 req_xfer;
  logic [sched_cfg_pkg::CORE_COUNT-1:0] req_onehot;
  logic [sched_cfg_pkg::SLOT_WIDTH-1:0] head_slot;

  // Descriptor register is empty or drains this cycle
  assign out_free     = !rx_desc_valid || rx_desc_ready;
  assign rx_req_ready = slots.slot_avail[rx_req_core] && out_free;
  assign req_xfer     = rx_req_valid && rx_req_ready;
  assign head_slot    = slots.slot_head[rx_req_core];

  always_comb begin
    req_onehot = '0;
    req_onehot[rx_req_core] = 1'b1;
  end

  // Pop lands on the same edge the descriptor is captured
  assign slots.slot_pop = req_xfer ? req_onehot : '0;

  always_ff @(posedge clk) begin
    if (rst_r)
      rx_desc_valid <= 1'b0;
    else if (req_xfer)
      rx_desc_valid <= 1'b1;
    else if (rx_desc_ready)
      rx_desc_valid <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (req_xfer) begin
      rx_desc <= {rx_req_core,
                  {(sched_cfg_pkg::TAG_WIDTH - sched_cfg_pkg::SLOT_WIDTH){1'b0}},
                  head_slot};
    end
  end

  // Host readback of one core's free slots
  always_ff @(posedge clk) begin
    stat_slot_count <= slots.slot_count[stat_core];
  end

endmodule

`default_nettype wire

/* slot_keeper.sv */
`timescale 1ns/1ps
`default_nettype none

module slot_keeper #(
  parameter int core_index = 0
) (
  input  logic    clk,
  input  logic    rst_r,
  slot_if.keeper  slots
);

  logic                                     init_q;
  logic                                     push_q;
  logic [sched_cfg_pkg::SLOT_WIDTH-1:0]     value_q;
  logic [sched_cfg_pkg::SLOT_WIDTH-1:0]     init_n;

  logic [sched_cfg_pkg::SLOT_WIDTH-1:0]     mem [sched_cfg_pkg::SLOT_COUNT];
  logic [sched_cfg_pkg::SLOT_PTR_WIDTH-1:0] rd_ptr;
  logic [sched_cfg_pkg::SLOT_PTR_WIDTH-1:0] wr_ptr;
  logic [sched_cfg_pkg::SLOT_WIDTH-1:0]     count;
  logic                                     pop;
  logic                                     do_push;

  // Request stage, the FIFO acts one cycle after the decoder
  always_ff @(posedge clk) begin
    value_q <= slots.slot_value;
    if (rst_r) begin
      init_q <= 1'b0;
      push_q <= 1'b0;
    end else begin
      init_q <= slots.slot_init[core_index];
      push_q <= slots.slot_push[core_index];
    end
  end

  assign init_n  = (value_q > sched_cfg_pkg::SLOT_MAX) ? sched_cfg_pkg::SLOT_MAX : value_q;
  assign pop     = slots.slot_pop[core_index] && (count != '0);
  // A push into a full FIFO is lost
  assign do_push = push_q && ((count != sched_cfg_pkg::SLOT_MAX) || pop);

  always_ff @(posedge clk) begin
    if (init_q) begin
      for (int i = 0; i < sched_cfg_pkg::SLOT_COUNT; i++)
        mem[i] <= i[sched_cfg_pkg::SLOT_WIDTH-1:0] + 1'b1;
    end else if (do_push) begin
      mem[wr_ptr] <= value_q;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else if (init_q) begin
      rd_ptr <= '0;
      wr_ptr <= init_n[sched_cfg_pkg::SLOT_PTR_WIDTH-1:0];
      count  <= init_n;
    end else begin
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (do_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop && !do_push)
        count <= count - 1'b1;
      else if (do_push && !pop)
        count <= count + 1'b1;
    end
  end

  assign slots.slot_avail[core_index] = count != '0;
  assign slots.slot_head[core_index]  = mem[rd_ptr];
  assign slots.slot_count[core_index] = count;

endmodule

`default_nettype wire

/* ctrl_msg_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_msg_decoder (
  input  logic                                    clk,
  input  logic                                    rst_r,
  input  logic [ctrl_msg_pkg::CTRL_WIDTH-1:0]     ctrl_in_data,
  input  logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] ctrl_in_src,
  input  logic                                    ctrl_in_valid,
  output logic                                    ctrl_in_ready,
  output logic [ctrl_msg_pkg::CTRL_WIDTH-1:0]     ctrl_out_data,
  output logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] ctrl_out_dest,
  output logic                                    ctrl_out_valid,
  input  logic                                    ctrl_out_ready,
  slot_if.decoder                                 slots
);

  ctrl_msg_pkg::ctrl_word_u in_word;
  ctrl_msg_pkg::ctrl_word_u out_word;

  logic                                 is_free;
  logic                                 is_init;
  logic                                 is_done;
  logic                                 in_xfer;
  logic [sched_cfg_pkg::CORE_COUNT-1:0] src_onehot;

  logic [ctrl_msg_pkg::DESC_WIDTH-1:0]    q_payload [sched_cfg_pkg::PKT_DONE_DEPTH];
  logic [sched_cfg_pkg::CORE_ID_WIDTH-1:0] q_src    [sched_cfg_pkg::PKT_DONE_DEPTH];
  // One extra bit tells a full queue from an empty one
  logic [sched_cfg_pkg::PKT_DONE_PTR_WIDTH:0] q_wr_ptr;
  logic [sched_cfg_pkg::PKT_DONE_PTR_WIDTH:0] q_rd_ptr;
  logic                                       q_full;
  logic                                       q_deq;

  assign in_word = ctrl_in_data;
  assign is_free = in_word.slot_view.msg_type == ctrl_msg_pkg::MSG_SLOT_FREE;
  assign is_init = in_word.slot_view.msg_type == ctrl_msg_pkg::MSG_SLOT_INIT;
  assign is_done = in_word.desc_view.msg_type == ctrl_msg_pkg::MSG_PKT_DONE;

  // Only packet-done words can be held back
  assign ctrl_in_ready = !is_done || !q_full;
  assign in_xfer       = ctrl_in_valid && ctrl_in_ready;

  always_comb begin
    src_onehot = '0;
    src_onehot[ctrl_in_src] = 1'b1;
  end

  always_ff @(posedge clk) begin
    slots.slot_value <= in_word.slot_view.slot;
    if (rst_r) begin
      slots.slot_push <= '0;
      slots.slot_init <= '0;
    end else begin
      slots.slot_push <= (in_xfer && is_free) ? src_onehot : '0;
      slots.slot_init <= (in_xfer && is_init) ? src_onehot : '0;
    end
  end

  assign q_full = (q_wr_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH] !=
                   q_rd_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH]) &&
                  (q_wr_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH-1:0] ==
                   q_rd_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH-1:0]);
  assign ctrl_out_valid = q_wr_ptr != q_rd_ptr;
  assign q_deq          = ctrl_out_valid && ctrl_out_ready;

  always_ff @(posedge clk) begin
    if (in_xfer && is_done) begin
      q_payload[q_wr_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH-1:0]] <= in_word.desc_view.payload;
      q_src[q_wr_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH-1:0]]     <= ctrl_in_src;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_r) begin
      q_wr_ptr <= '0;
      q_rd_ptr <= '0;
    end else begin
      if (in_xfer && is_done)
        q_wr_ptr <= q_wr_ptr + 1'b1;
      if (q_deq)
        q_rd_ptr <= q_rd_ptr + 1'b1;
    end
  end

  // Head of the queue goes back to its source as a send-out word
  always_comb begin
    out_word.desc_view.msg_type = ctrl_msg_pkg::MSG_SEND_OUT;
    out_word.desc_view.payload  = q_payload[q_rd_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH-1:0]];
  end

  assign ctrl_out_data = out_word;
  assign ctrl_out_dest = q_src[q_rd_ptr[sched_cfg_pkg::PKT_DONE_PTR_WIDTH-1:0]];

endmodule

`default_nettype wire

/* slot_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface slot_if;

  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_push;
  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_init;
  logic [sched_cfg_pkg::SLOT_WIDTH-1:0] slot_value;

  logic [sched_cfg_pkg::CORE_COUNT-1:0]                                 slot_avail;
  logic [sched_cfg_pkg::CORE_COUNT-1:0][sched_cfg_pkg::SLOT_WIDTH-1:0] slot_head;
  logic [sched_cfg_pkg::CORE_COUNT-1:0][sched_cfg_pkg::SLOT_WIDTH-1:0] slot_count;

  logic [sched_cfg_pkg::CORE_COUNT-1:0] slot_pop;

  modport decoder (output slot_push, slot_init, slot_value);

  modport keeper (input slot_push, slot_init, slot_value, slot_pop,
                  output slot_avail, slot_head, slot_count);

  modport allocator (input slot_avail, slot_head, slot_count, output slot_pop);

endinterface

`default_nettype wire

/* ctrl_msg_pkg.sv */
`default_nettype none

package ctrl_msg_pkg;

  localparam int CTRL_WIDTH        = 36;
  localparam int MSG_TYPE_WIDTH    = 4;
  localparam int DESC_WIDTH        = CTRL_WIDTH - MSG_TYPE_WIDTH;
  localparam int SLOT_FIELD_OFFSET = 16;

  // Incoming message codes
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_FREE = 4'd0;
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_PKT_DONE  = 4'd1;
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SLOT_INIT = 4'd3;

  // Outgoing message code
  localparam logic [MSG_TYPE_WIDTH-1:0] MSG_SEND_OUT  = 4'd0;

  // Same 36-bit word, read either as a slot message or as a descriptor
  typedef union packed {
    struct packed {
      logic [MSG_TYPE_WIDTH-1:0]                                        msg_type;
      logic [DESC_WIDTH-SLOT_FIELD_OFFSET-sched_cfg_pkg::SLOT_WIDTH-1:0] pad_hi;
      logic [sched_cfg_pkg::SLOT_WIDTH-1:0]                             slot;
      logic [SLOT_FIELD_OFFSET-1:0]                                     pad_lo;
    } slot_view;
    struct packed {
      logic [MSG_TYPE_WIDTH-1:0] msg_type;
      logic [DESC_WIDTH-1:0]     payload;
    } desc_view;
  } ctrl_word_u;

endpackage

`default_nettype wire

/* sched_cfg_pkg.sv */
`default_nettype none

package sched_cfg_pkg;

  localparam int CORE_COUNT    = 4;
  localparam int SLOT_COUNT    = 8;
  localparam int SLOT_WIDTH    = $clog2(SLOT_COUNT + 1);
  localparam int CORE_ID_WIDTH = $clog2(CORE_COUNT);
  localparam int TAG_WIDTH     = (SLOT_WIDTH > 5) ? SLOT_WIDTH : 5;
  localparam int ID_TAG_WIDTH  = CORE_ID_WIDTH + TAG_WIDTH;

  // Keeper FIFO addressing, SLOT_COUNT is a power of two
  localparam int SLOT_PTR_WIDTH = $clog2(SLOT_COUNT);
  localparam logic [SLOT_WIDTH-1:0] SLOT_MAX = SLOT_WIDTH'(SLOT_COUNT);

  // Packet-done queue
  localparam int PKT_DONE_DEPTH     = 4;
  localparam int PKT_DONE_PTR_WIDTH = $clog2(PKT_DONE_DEPTH);

endpackage

`default_nettype wire
